// File: bench/ctrlTrace.txt
# instr(hex) icc(hex NZVC) memStart cycles externalTrap class index trap cause
# class 0 aluReg .. 11 illegal, cause 0 none 1 external 2 software 3 illegal
82000000 0 3 0 0 0
82002005 0 4 0 1 0
82100000 0 3 0 0 0
83282003 0 5 0 1 0
03001234 0 3 0 5 0
02800010 4 3 0 6 0
02800010 0 4 0 7 0
22800010 0 3 0 8 0
22800010 4 3 0 6 0
10800004 0 3 0 6 0
30800004 0 3 0 8 0
00800004 0 3 0 9 0
20800004 0 3 0 8 0
04800008 8 3 0 6 0
06800008 a 3 0 7 0
08800008 1 4 0 6 0
12800008 4 3 0 7 0
18800008 0 3 0 6 0
3e800008 2 3 0 8 0
40000010 0 3 0 3 0
81c3e008 0 3 0 4 0
c2000000 0 5 0 2 0
c2202004 0 4 0 2 0
91d02010 0 3 0 10 2
93d02010 4 3 0 9 0
81600000 0 3 0 11 3
82000000 0 3 1 0 1
02800010 0 4 1 7 1

// File: tb.f
logic/sparcCtrlPkg.sv
logic/condEval.sv
logic/instrDecode.sv
logic/seqState.sv
logic/ctrlWordGen.sv
logic/controlUnit.sv
bench/clockGen.sv
bench/controlUnit_properties.sv
bench/controlUnitTb.sv

// File: bench/controlUnitTb.sv
module controlUnitTb;
	import sparcCtrlPkg::*;

	localparam int waitLimit = 200;

	logic Clk;
	logic Clr;
	instr_t ir;
	icc_t icc;
	logic MFC;
	logic externalTrap;
	ctrlWord_t ctrl;
	logic memStart;

	// What one instruction did to the control word
	int rfWrites;
	operandSel_t rfSel;
	int targetLoads;
	int npcOnlyLoads;
	int aluJumps;
	int linkWrites;
	int trapVectors;
	int mdrWrites;
	int dataAccesses;
	trapCause_t causeSeen;

	clockGen clockGen_i (
		.Clk(Clk),
		.Clr(Clr)
	);

	controlUnit controlUnit_i (
		.Clk(Clk),
		.Clr(Clr),
		.ir(ir),
		.icc(icc),
		.MFC(MFC),
		.externalTrap(externalTrap),
		.ctrl(ctrl),
		.memStart(memStart)
	);

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("error at time %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			abortRun("the control unit gave a wrong value");
		end
	endtask

	task automatic clearNotes();
		rfWrites = 0;
		rfSel = opReg;
		targetLoads = 0;
		npcOnlyLoads = 0;
		aluJumps = 0;
		linkWrites = 0;
		trapVectors = 0;
		mdrWrites = 0;
		dataAccesses = 0;
		causeSeen = causeNone;
	endtask

	// Outputs are stable at the falling edge
	task automatic sampleCycle();
		@(negedge Clk);
		if (ctrl.rfWrite) begin
			rfWrites++;
			rfSel = ctrl.operandSel;
		end
		if (ctrl.pcLoad && ctrl.pcSrc == pcTarget)
			targetLoads++;
		if (ctrl.npcLoad && !ctrl.pcLoad)
			npcOnlyLoads++;
		if (ctrl.pcLoad && ctrl.pcSrc == pcAlu)
			aluJumps++;
		if (ctrl.linkWrite)
			linkWrites++;
		if (ctrl.pcLoad && ctrl.pcSrc == pcTrap)
			trapVectors++;
		if (ctrl.mdrLoad && ctrl.rfWrite)
			mdrWrites++;
		if (ctrl.trapEnter)
			causeSeen = ctrl.trapCause;
	endtask

	// Memory model entered on the first cycle memStart is seen
	task automatic serveAccess(input int cycles, input logic fetch, input instr_t word,
			input icc_t flags, input logic trapReq);
		int highCount;
		highCount = 1;
		if (fetch) begin
			checkValue(ctrl.memRead, 1, "memRead of instruction fetch");
			checkValue(ctrl.marLoad, 1, "marLoad of instruction fetch");
		end
		repeat (cycles - 3) begin
			sampleCycle();
			checkValue(memStart, 1, "memStart while waiting for MFC");
			highCount++;
		end
		@(posedge Clk);
		MFC <= 1'b1;
		if (fetch) begin
			ir <= word;
			icc <= flags;
			externalTrap <= trapReq;
		end
		sampleCycle();
		if (memStart)
			highCount++;
		@(posedge Clk);
		MFC <= 1'b0;
		sampleCycle();
		while (memStart) begin
			highCount++;
			if (highCount > waitLimit)
				abortRun("memStart stayed high after MFC for too long");
			sampleCycle();
		end
		checkValue(highCount, cycles, "cycles with memStart high");
	endtask

	task automatic runLine(input instr_t word, input icc_t flags, input int cycles,
			input logic trapReq, input int expCls, input int expCause);
		int guard;
		logic isLoad;
		logic expRf;
		instrClass_t cls;
		operandSel_t expSel;
		clearNotes();
		serveAccess(cycles, 1'b1, word, flags, trapReq);
		guard = 0;
		while (!(memStart && ctrl.irLoad)) begin
			if (memStart) begin
				dataAccesses++;
				checkValue(ctrl.memRead, !word[lsDirBit], "memRead of data access");
				serveAccess(cycles, 1'b0, word, flags, trapReq);
			end else begin
				if (ctrl.trapEnter) begin
					@(posedge Clk);
					externalTrap <= 1'b0;
				end
				sampleCycle();
			end
			guard++;
			if (guard > waitLimit)
				abortRun("no instruction fetch followed within the time limit");
		end

		cls = instrClass_t'(expCls);
		isLoad = (cls == clsLoadStore) && !word[lsDirBit];
		expRf = (cls == clsAluReg || cls == clsAluImm || cls == clsSethi || isLoad);
		expSel = isLoad ? opMem : (cls == clsAluReg ? opReg : opImm);
		checkValue(rfWrites, expRf, "rfWrite pulses");
		if (expRf)
			checkValue(rfSel, expSel, "operandSel at rfWrite");
		checkValue(targetLoads, cls == clsCall || cls == clsBranchTaken, "pcTarget loads");
		checkValue(npcOnlyLoads, cls == clsBranchAnnul, "npcLoad without pcLoad");
		checkValue(aluJumps, cls == clsJmpl, "pcAlu loads");
		checkValue(linkWrites, (cls == clsCall || cls == clsJmpl) + (expCause != 0),
			"linkWrite pulses");
		checkValue(dataAccesses, cls == clsLoadStore, "data accesses");
		checkValue(mdrWrites, isLoad, "mdrLoad with rfWrite");
		checkValue(causeSeen, expCause, "trap cause");
		checkValue(trapVectors, expCause != 0, "pcTrap loads");
	endtask

	initial begin
		int fd;
		int count;
		int guard;
		int edges;
		int lines;
		int cycles;
		int expCls;
		int expCause;
		string line;
		instr_t word;
		icc_t flags;
		logic trapReq;
		ir <= '0;
		icc <= '0;
		MFC <= 1'b0;
		externalTrap <= 1'b0;
		lines = 0;
		fd = $fopen("bench/ctrlTrace.txt", "r");
		if (fd == 0)
			abortRun("cannot open the trace file bench/ctrlTrace.txt");

		guard = 0;
		while (Clr !== 1'b1) begin
			sampleCycle();
			checkValue(ctrl, 0, "ctrl during reset");
			checkValue(memStart, 0, "memStart during reset");
			guard++;
			if (guard > waitLimit)
				abortRun("reset was never released");
		end

		// First fetch on the fourth edge after release
		edges = 0;
		do begin
			sampleCycle();
			edges++;
			if (edges < 3)
				checkValue(ctrl, 0, "ctrl after reset");
			if (edges > waitLimit)
				abortRun("no fetch after reset within the time limit");
		end while (!memStart);
		checkValue(edges, 4, "edges from reset release to first memStart");
		checkValue(ctrl.irLoad, 1, "irLoad of first fetch");

		while (!$feof(fd)) begin
			line = "";
			count = $fgets(line, fd);
			if (count > 1 && line.getc(0) != "#") begin
				count = $sscanf(line, "%h %h %d %d %d %d", word, flags, cycles, trapReq,
					expCls, expCause);
				if (count != 6)
					abortRun("a line of the trace file is malformed");
				if (cycles < 3 || cycles > waitLimit)
					abortRun("a memory delay in the trace file is out of range");
				runLine(word, flags, cycles, trapReq, expCls, expCause);
				lines++;
			end
		end
		$fclose(fd);
		if (lines == 0)
			abortRun("the trace file holds no instructions");
		if (controlUnit_i.controlUnit_properties_i.failCount != 0)
			abortRun("an assertion bound to the control unit failed");
		else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

// File: bench/controlUnit_properties.sv
module controlUnit_properties (
	input logic Clk,
	input logic Clr,
	input sparcCtrlPkg::ctrlWord_t ctrl,
	input logic memStart,
	input logic MFC
);
	import sparcCtrlPkg::*;

	// Number of assertion failures so far
	int failCount = 0;

	// MFC is sampled two clocks before the registered request drops
	memStartFall: assert property (@(posedge Clk) disable iff (!Clr)
		$fell(memStart) |-> $past(MFC, 2))
		else begin
			$error("memStart dropped without a completed memory access");
			failCount++;
		end

	noJumpDuringTrap: assert property (@(posedge Clk) disable iff (!Clr)
		!(ctrl.pcLoad && ctrl.trapEnter))
		else begin
			$error("pcLoad and trapEnter are high in the same cycle");
			failCount++;
		end

	// Quiet after reset until one PC advance and then the first fetch
	resetQuiet: assert property (@(posedge Clk)
		$rose(Clr) |-> (ctrl == '0 && !memStart)[*3] ##1 (ctrl.pcLoad && !memStart)
			##1 memStart)
		else begin
			$error("control word not quiet up to the first fetch after reset");
			failCount++;
		end

endmodule

bind controlUnit controlUnit_properties controlUnit_properties_i (
	.Clk(Clk),
	.Clr(Clr),
	.ctrl(ctrl),
	.memStart(memStart),
	.MFC(MFC)
);

// File: bench/clockGen.sv
module clockGen (
	output logic Clk,
	output logic Clr
);

	// Period of 4 with the first rising edge at time 2
	initial begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;
	end

	// Released between edges so the flops never see it change on a clock
	initial begin
		Clr = 1'b0;
		repeat (5) @(posedge Clk);
		#1 Clr = 1'b1;
	end

endmodule

// File: logic/controlUnit.sv
module controlUnit (
	input logic Clk,
	input logic Clr,
	input sparcCtrlPkg::instr_t ir,
	input sparcCtrlPkg::icc_t icc,
	input logic MFC,
	input logic externalTrap,
	output sparcCtrlPkg::ctrlWord_t ctrl,
	output logic memStart
);
	import sparcCtrlPkg::*;

	instrClass_t cls;
	seqStatus_t status;

	instrDecode instrDecode_i (
		.ir(ir),
		.icc(icc),
		.cls(cls)
	);

	seqState seqState_i (
		.Clk(Clk),
		.Clr(Clr),
		.cls(cls),
		.ir(ir),
		.MFC(MFC),
		.externalTrap(externalTrap),
		.status(status)
	);

	ctrlWordGen ctrlWordGen_i (
		.Clk(Clk),
		.Clr(Clr),
		.status(status),
		.ir(ir),
		.ctrl(ctrl),
		.memStart(memStart)
	);

endmodule

// File: logic/ctrlWordGen.sv
module ctrlWordGen (
	input logic Clk,
	input logic Clr,
	input sparcCtrlPkg::seqStatus_t status,
	input sparcCtrlPkg::instr_t ir,
	output sparcCtrlPkg::ctrlWord_t ctrl,
	output logic memStart
);
	import sparcCtrlPkg::*;

	ctrlWord_t word;

	always_comb begin
		word = '0;
		case (status.state)
			stAdvance: begin
				word.pcLoad = 1'b1;
				word.npcLoad = 1'b1;
				word.pcSrc = pcSeq;
			end
			stFetch: begin
				word.memStart = 1'b1;
				word.memRead = 1'b1;
				word.marLoad = 1'b1;
				word.irLoad = 1'b1;
			end
			stAluReg: begin
				word.rfWrite = 1'b1;
				word.operandSel = opReg;
			end
			stAluImm, stSethi: begin
				word.rfWrite = 1'b1;
				word.operandSel = opImm;
			end
			stLoadWait: begin
				word.memStart = 1'b1;
				word.memRead = 1'b1;
			end
			stLoadWrite: begin
				word.mdrLoad = 1'b1;
				word.rfWrite = 1'b1;
				word.operandSel = opMem;
			end
			// Write cycle with memRead low
			stStoreWait: word.memStart = 1'b1;
			stCall: word.linkWrite = 1'b1;
			stCallLink, stBranch: begin
				word.pcLoad = 1'b1;
				word.npcLoad = 1'b1;
				word.pcSrc = pcTarget;
			end
			// Link and jump in one step
			// Target is rs1 plus rs2 or simm13
			stJmpl: begin
				word.linkWrite = 1'b1;
				word.operandSel = ir[immBit] ? opImm : opReg;
				word.pcLoad = 1'b1;
				word.npcLoad = 1'b1;
				word.pcSrc = pcAlu;
			end
			// Step nPC past the delay slot
			stAnnul: word.npcLoad = 1'b1;
			stTrapEntry: begin
				word.trapEnter = 1'b1;
				word.trapCause = status.cause;
			end
			stTrapSave: word.linkWrite = 1'b1;
			stTrapVector: begin
				word.pcLoad = 1'b1;
				word.npcLoad = 1'b1;
				word.pcSrc = pcTrap;
			end
			default: word = '0;
		endcase
	end

	// Control word follows the state by one clock
	always_ff @(posedge Clk or negedge Clr) begin
		if (!Clr)
			ctrl <= '0;
		else
			ctrl <= word;
	end

	assign memStart = ctrl.memStart;

endmodule

// File: logic/seqState.sv
module seqState (
	input logic Clk,
	input logic Clr,
	input sparcCtrlPkg::instrClass_t cls,
	input sparcCtrlPkg::instr_t ir,
	input logic MFC,
	input logic externalTrap,
	output sparcCtrlPkg::seqStatus_t status
);
	import sparcCtrlPkg::*;

	ctrlState_t state;
	ctrlState_t stateNext;
	trapCause_t cause;
	trapCause_t causeNext;

	always_ff @(posedge Clk or negedge Clr) begin
		if (!Clr) begin
			state <= stReset;
			cause <= causeNone;
		end else begin
			state <= stateNext;
			cause <= causeNext;
		end
	end

	always_comb begin
		stateNext = state;
		case (state)
			stReset: stateNext = stInit;
			stInit: stateNext = stAdvance;
			// External traps are taken only at this instruction boundary
			stAdvance: stateNext = externalTrap ? stTrapEntry : stFetch;
			stFetch: stateNext = MFC ? stDecode : stFetch;
			stDecode: begin
				case (cls)
					clsAluReg: stateNext = stAluReg;
					clsAluImm: stateNext = stAluImm;
					clsLoadStore: stateNext = stLsAddr;
					clsCall: stateNext = stCall;
					clsJmpl: stateNext = stJmpl;
					clsSethi: stateNext = stSethi;
					clsBranchTaken: stateNext = stBranch;
					clsBranchAnnul: stateNext = stAnnul;
					clsSoftTrap, clsIllegal: stateNext = stTrapEntry;
					default: stateNext = stAdvance;
				endcase
			end
			stAluReg, stAluImm, stSethi: stateNext = stAdvance;
			stLsAddr: stateNext = ir[lsDirBit] ? stStoreWait : stLoadWait;
			stLoadWait: stateNext = MFC ? stLoadWrite : stLoadWait;
			stLoadWrite: stateNext = stAdvance;
			stStoreWait: stateNext = MFC ? stAdvance : stStoreWait;
			stCall: stateNext = stCallLink;
			// PC already holds the delay slot so fetch it directly
			stCallLink, stJmpl, stBranch: stateNext = stFetch;
			stAnnul: stateNext = stAdvance;
			stTrapEntry: stateNext = stTrapSave;
			stTrapSave: stateNext = stTrapVector;
			stTrapVector: stateNext = stAdvance;
			default: stateNext = stReset;
		endcase
	end

	// Cause is latched on the way into trap entry and dropped after the vector
	always_comb begin
		causeNext = cause;
		if (state == stTrapVector)
			causeNext = causeNone;
		if (stateNext == stTrapEntry) begin
			if (state == stAdvance)
				causeNext = causeExternal;
			else if (cls == clsSoftTrap)
				causeNext = causeSoftware;
			else
				causeNext = causeIllegal;
		end
	end

	assign status.state = state;
	assign status.cause = cause;

endmodule

// File: logic/instrDecode.sv
module instrDecode (
	input sparcCtrlPkg::instr_t ir,
	input sparcCtrlPkg::icc_t icc,
	output sparcCtrlPkg::instrClass_t cls
);
	import sparcCtrlPkg::*;

	fmt_t fmt;
	op2_t op2;
	op3_t op3;
	cond_t cond;
	logic annul;
	logic imm;
	logic condTrue;

	assign fmt = ir[31:30];
	assign op2 = ir[24:22];
	assign op3 = ir[24:19];
	assign cond = ir[28:25];
	assign annul = ir[annulBit];
	assign imm = ir[immBit];

	// Bicc and Ticc share the condition field position
	condEval condEval_i (
		.cond(cond),
		.icc(icc),
		.taken(condTrue)
	);

	always_comb begin
		cls = clsIllegal;
		case (fmt)
			fmtBranch: begin
				if (op2 == op2Sethi)
					cls = clsSethi;
				else if (op2 == op2Bicc) begin
					if (cond == condAlways && annul)
						cls = clsBranchAnnul;
					else if (condTrue)
						cls = clsBranchTaken;
					else if (annul)
						cls = clsBranchAnnul;
					else if (cond == condNever)
						cls = clsNop;
					else
						cls = clsBranchNotTaken;
				end
			end
			fmtCall: cls = clsCall;
			fmtAlu: begin
				case (op3) inside
					op3AluBasic, op3AluCarry, op3Sll, op3Srl, op3Sra: begin
						cls = imm ? clsAluImm : clsAluReg;
					end
					op3Jmpl: cls = clsJmpl;
					// Trap on a true condition and do nothing otherwise
					op3Ticc: cls = condTrue ? clsSoftTrap : clsNop;
					default: cls = clsIllegal;
				endcase
			end
			fmtMem: cls = clsLoadStore;
			default: cls = clsIllegal;
		endcase
	end

endmodule

// File: logic/condEval.sv
module condEval (
	input sparcCtrlPkg::cond_t cond,
	input sparcCtrlPkg::icc_t icc,
	output logic taken
);

	logic n;
	logic z;
	logic v;
	logic c;
	logic base;

	assign {n, z, v, c} = icc;

	// Low three bits select the test
	always_comb begin
		case (cond[2:0])
			3'd0: base = 1'b0;
			3'd1: base = z;
			3'd2: base = z | (n ^ v);
			3'd3: base = n ^ v;
			3'd4: base = c | z;
			3'd5: base = c;
			3'd6: base = n;
			default: base = v;
		endcase
	end

	// Bit 3 gives the complementary condition so never becomes always
	assign taken = base ^ cond[3];

endmodule

// File: logic/sparcCtrlPkg.sv
package sparcCtrlPkg;

	// Instruction word and field types
	typedef logic [31:0] instr_t;
	typedef logic [3:0] icc_t;
	typedef logic [3:0] cond_t;
	typedef logic [5:0] op3_t;
	typedef logic [2:0] op2_t;
	typedef logic [1:0] fmt_t;

	// Format field in bits 31:30
	localparam fmt_t fmtBranch = 2'b00;
	localparam fmt_t fmtCall = 2'b01;
	localparam fmt_t fmtAlu = 2'b10;
	localparam fmt_t fmtMem = 2'b11;

	localparam op2_t op2Bicc = 3'b010;
	localparam op2_t op2Sethi = 3'b100;

	// ADD/AND/OR/XOR/SUB/ANDN/ORN/XNOR and their cc forms
	// The ? bits match anything
	localparam op3_t op3AluBasic = 6'b0?0???;
	// ADDX/SUBX and their cc forms
	localparam op3_t op3AluCarry = 6'b0?1?00;
	localparam op3_t op3Sll = 6'b100101;
	localparam op3_t op3Srl = 6'b100110;
	localparam op3_t op3Sra = 6'b100111;
	localparam op3_t op3Jmpl = 6'b111000;
	localparam op3_t op3Ticc = 6'b111010;

	localparam cond_t condNever = 4'b0000;
	localparam cond_t condAlways = 4'b1000;

	// Single-bit fields
	localparam int immBit = 13;
	localparam int annulBit = 29;
	localparam int lsDirBit = 21;

	typedef enum logic [3:0] {
		clsAluReg, clsAluImm, clsLoadStore, clsCall, clsJmpl, clsSethi,
		clsBranchTaken, clsBranchNotTaken, clsBranchAnnul, clsNop,
		clsSoftTrap, clsIllegal
	} instrClass_t;

	typedef enum logic [4:0] {
		stReset, stInit, stAdvance, stFetch, stDecode,
		stAluReg, stAluImm, stLsAddr, stLoadWait, stLoadWrite, stStoreWait,
		stCall, stCallLink, stJmpl, stSethi, stBranch, stAnnul,
		stTrapEntry, stTrapSave, stTrapVector
	} ctrlState_t;

	typedef enum logic [1:0] {causeNone, causeExternal, causeSoftware, causeIllegal} trapCause_t;

	// Next-PC source
	typedef enum logic [1:0] {pcSeq, pcTarget, pcAlu, pcTrap} pcSrc_t;

	typedef enum logic [1:0] {opReg, opImm, opPc, opMem} operandSel_t;

	typedef struct packed {
		logic pcLoad;
		logic npcLoad;
		pcSrc_t pcSrc;
		logic irLoad;
		logic marLoad;
		logic mdrLoad;
		logic memStart;
		logic memRead;
		logic rfWrite;
		operandSel_t operandSel;
		logic linkWrite;
		logic trapEnter;
		trapCause_t trapCause;
	} ctrlWord_t;

	// Sequencer state together with the pending trap cause
	typedef struct packed {
		ctrlState_t state;
		trapCause_t cause;
	} seqStatus_t;

endpackage
